/* filelist.f */
+incdir+design
design/backend_pkg.sv
design/reg_file.sv
design/exec_alu.sv
design/lsu_wb.sv
design/data_ram.sv
design/backend_pipeline.sv
design/backend_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_backend
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wall
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# grep sets the exit status of the pipeline
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_backend.sv */
module tb_backend;
	timeunit 1ns;
	timeprecision 1ps;
	import backend_pkg::*;

	localparam int N           = 40;
	localparam int LIMIT       = N * 8 + 100;
	localparam int DRAIN_LIMIT = 32;

	logic clk, rst_n;
	logic issue_valid_i, issue_ready_o;
	op_e  issue_op_i;
	logic [4:0] issue_rd_i, issue_rj_i, issue_rk_i;
	logic [19:0] issue_imm_i;
	logic reg_w_en_o, wb_cyc_o, wb_we_o;
	logic [4:0] reg_w_addr_o;
	logic [31:0] reg_w_data_o;
	logic [7:0] wb_adr_o;

	// program table
	op_e ins_op [N];
	logic [4:0] ins_rd [N], ins_rj [N], ins_rk [N];
	logic [19:0] ins_imm [N];
	int n_ins = 0;

	// expected write-backs and bus accesses
	logic [4:0] exp_rd [N];
	logic [31:0] exp_val [N];
	int exp_count = 0;
	logic bus_we [N];
	logic [7:0] bus_adr [N];
	int bus_count = 0;

	logic done = 1'b0;
	int wb_seen, err_count, cycles = 0;
	logic report_done;
	int seed = 32'h95322bc4;

	tb_clock i_clk (.clk, .rst_n);

	backend_top i_dut (
		.clk, .rst_n, .issue_valid_i, .issue_op_i, .issue_rd_i, .issue_rj_i,
		.issue_rk_i, .issue_imm_i, .issue_ready_o, .reg_w_en_o, .reg_w_addr_o,
		.reg_w_data_o, .wb_cyc_o, .wb_we_o, .wb_adr_o
	);

	tb_checker #(.N(N)) i_chk (
		.clk, .rst_n, .issue_ready_i (issue_ready_o),
		.reg_w_en_i (reg_w_en_o), .reg_w_addr_i (reg_w_addr_o),
		.reg_w_data_i (reg_w_data_o), .wb_cyc_i (wb_cyc_o), .wb_we_i (wb_we_o),
		.wb_adr_i (wb_adr_o), .exp_rd_i (exp_rd), .exp_val_i (exp_val),
		.exp_count_i (exp_count), .bus_we_i (bus_we), .bus_adr_i (bus_adr),
		.bus_count_i (bus_count), .done_i (done), .wb_seen_o (wb_seen),
		.err_count_o (err_count), .report_done_o (report_done)
	);

	task automatic put_ins(op_e op, int rd, int rj, int rk, logic [19:0] imm);
		ins_op[n_ins]  = op;
		ins_rd[n_ins]  = rd[4:0];
		ins_rj[n_ins]  = rj[4:0];
		ins_rk[n_ins]  = rk[4:0];
		ins_imm[n_ins] = imm;
		n_ins++;
	endtask

	task automatic build_program();
		put_ins(OP_LU12I, 1, 0, 0, 20'h12345);
		put_ins(OP_ADDI, 1, 1, 0, 20'h678);
		put_ins(OP_ADDI, 2, 0, 0, 20'hffd);   // -3
		put_ins(OP_ADD, 3, 1, 2, 0);          // dependent chain
		put_ins(OP_SUB, 4, 3, 1, 0);
		put_ins(OP_XOR, 5, 4, 1, 0);
		put_ins(OP_AND, 6, 5, 3, 0);
		put_ins(OP_OR, 7, 6, 2, 0);
		put_ins(OP_ADDI, 8, 0, 0, 20'h4);
		put_ins(OP_SLL, 9, 1, 8, 0);
		put_ins(OP_SRL, 10, 2, 8, 0);
		put_ins(OP_SLT, 11, 2, 1, 0);
		put_ins(OP_SLT, 12, 1, 2, 0);
		put_ins(OP_ADDI, 13, 0, 0, 20'h100);  // memory base
		put_ins(OP_ST_W, 0, 13, 1, 20'h0);
		put_ins(OP_LD_W, 14, 13, 0, 20'h0);
		put_ins(OP_ADD, 15, 14, 14, 0);       // load-use
		put_ins(OP_ST_W, 0, 13, 15, 20'h4);
		put_ins(OP_ST_W, 0, 13, 3, 20'hff8);  // negative offset
		put_ins(OP_LD_W, 16, 13, 0, 20'h4);
		put_ins(OP_LD_W, 17, 13, 0, 20'hff8);
		put_ins(OP_SUB, 18, 17, 16, 0);
		put_ins(OP_ADDI, 0, 1, 0, 20'h5);     // r0 target gives no write-back
		put_ins(OP_ADD, 19, 0, 1, 0);
		put_ins(OP_LD_W, 0, 13, 0, 20'h0);
		put_ins(OP_OR, 20, 0, 0, 0);
		put_ins(OP_NOP, 0, 0, 0, 0);
		put_ins(OP_ADDI, 21, 20, 0, 20'h7ff);
		put_ins(OP_LU12I, 22, 0, 0, 20'hfffff);
		put_ins(OP_ADD, 23, 22, 21, 0);
		put_ins(OP_ST_W, 0, 13, 23, 20'h8);
		put_ins(OP_LD_W, 24, 13, 0, 20'h8);
		put_ins(OP_ST_W, 0, 13, 24, 20'hc);   // store data from a load
		put_ins(OP_LD_W, 25, 13, 0, 20'hc);
		put_ins(OP_XOR, 26, 25, 24, 0);
		put_ins(OP_SLT, 27, 22, 0, 0);
		put_ins(OP_SRL, 28, 22, 8, 0);
		put_ins(OP_SLL, 29, 27, 8, 0);
		put_ins(OP_SUB, 30, 29, 28, 0);
		put_ins(OP_ADD, 31, 30, 1, 0);
	endtask

	// in-order reference of registers and memory
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic [31:0] a, b, res, sext;
		logic [7:0] wadr;
		foreach (regs[i]) regs[i] = '0;
		foreach (mem[i]) mem[i] = '0;
		for (int i = 0; i < n_ins; i++) begin
			a    = regs[ins_rj[i]];
			b    = regs[ins_rk[i]];
			sext = {{20{ins_imm[i][11]}}, ins_imm[i][11:0]};
			wadr = 8'((a + sext) >> 2);
			res  = '0;
			case (ins_op[i])
				OP_ADD:   res = a + b;
				OP_SUB:   res = a - b;
				OP_AND:   res = a & b;
				OP_OR:    res = a | b;
				OP_XOR:   res = a ^ b;
				OP_SLL:   res = a << b[4:0];
				OP_SRL:   res = a >> b[4:0];
				OP_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				OP_ADDI:  res = a + sext;
				OP_LU12I: res = {ins_imm[i], 12'd0};
				OP_LD_W:  res = mem[wadr];
				default:  res = '0;
			endcase
			if (ins_op[i] == OP_ST_W) mem[wadr] = b;
			if (ins_op[i] == OP_LD_W || ins_op[i] == OP_ST_W) begin
				bus_we[bus_count]  = (ins_op[i] == OP_ST_W);
				bus_adr[bus_count] = wadr;
				bus_count++;
			end
			if (ins_op[i] != OP_NOP && ins_op[i] != OP_ST_W && ins_rd[i] != 0) begin
				exp_rd[exp_count]  = ins_rd[i];
				exp_val[exp_count] = res;
				exp_count++;
				regs[ins_rd[i]] = res;
			end
		end
	endtask

	task automatic issue_all();
		int gap;
		for (int i = 0; i < n_ins; i++) begin
			gap = $unsigned($random(seed)) % 3;
			if (gap > 0) begin
				issue_valid_i <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			issue_valid_i <= 1'b1;
			issue_op_i    <= ins_op[i];
			issue_rd_i    <= ins_rd[i];
			issue_rj_i    <= ins_rj[i];
			issue_rk_i    <= ins_rk[i];
			issue_imm_i   <= ins_imm[i];
			do @(posedge clk); while (!issue_ready_o); // hold until accepted
		end
		issue_valid_i <= 1'b0;
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		issue_valid_i = 1'b0;
		issue_op_i    = OP_NOP;
		issue_rd_i    = '0;
		issue_rj_i    = '0;
		issue_rk_i    = '0;
		issue_imm_i   = '0;
		build_program();
		run_model();
		wait (rst_n === 1'b1);
		@(posedge clk);
		issue_all();
		// let the last write-backs drain out of the pipe
		for (int w = 0; w < DRAIN_LIMIT && wb_seen < exp_count; w++) @(posedge clk);
		repeat (8) @(posedge clk); // drain to catch late extra pulses
		done <= 1'b1;
		wait (report_done === 1'b1);
		if (err_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule : tb_backend

/* test/tb_checker.sv */
module tb_checker #(
	parameter int N = 40
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        issue_ready_i,
	input  logic        reg_w_en_i,
	input  logic [4:0]  reg_w_addr_i,
	input  logic [31:0] reg_w_data_i,
	input  logic        wb_cyc_i,
	input  logic        wb_we_i,
	input  logic [7:0]  wb_adr_i,
	input  logic [4:0]  exp_rd_i [N],
	input  logic [31:0] exp_val_i [N],
	input  int          exp_count_i,
	input  logic        bus_we_i [N],
	input  logic [7:0]  bus_adr_i [N],
	input  int          bus_count_i,
	input  logic        done_i,
	output int          wb_seen_o,
	output int          err_count_o,
	output logic        report_done_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int   mismatches = 0;
	int   other_errs = 0;
	int   bus_seen   = 0;
	logic rst_q      = 1'b0;
	logic cyc_q      = 1'b0;

	initial wb_seen_o = 0;
	initial report_done_o = 1'b0;
	assign err_count_o = mismatches + other_errs;

	always @(posedge clk) begin
		// quiet during reset and the first cycle after it
		if ((!rst_n || !rst_q) && (reg_w_en_i || wb_cyc_i)) begin
			$display("write-back or bus cycle active during reset at %0t", $time);
			other_errs++;
		end
		if (!rst_n && issue_ready_i) begin // no issue while in reset
			$display("issue ready high during reset at %0t", $time);
			other_errs++;
		end
		if (rst_n && reg_w_en_i) begin
			if (wb_seen_o >= exp_count_i) begin
				$display("unexpected write-back beyond the %0d expected ones", exp_count_i);
				other_errs++;
			end else begin
				if (reg_w_addr_i !== exp_rd_i[wb_seen_o]) begin
					$display("mismatch reg_w_addr_o got %h expected %h (write-back %0d)",
						reg_w_addr_i, exp_rd_i[wb_seen_o], wb_seen_o);
					mismatches++;
				end
				if (reg_w_data_i !== exp_val_i[wb_seen_o]) begin
					$display("mismatch reg_w_data_o got %h expected %h (write-back %0d)",
						reg_w_data_i, exp_val_i[wb_seen_o], wb_seen_o);
					mismatches++;
				end
			end
			wb_seen_o <= wb_seen_o + 1;
		end
		if (rst_n && wb_cyc_i && !cyc_q) begin // start of a bus access
			if (bus_seen >= bus_count_i) begin
				$display("unexpected bus access beyond the %0d expected ones", bus_count_i);
				other_errs++;
			end else begin
				if (wb_we_i !== bus_we_i[bus_seen]) begin
					$display("mismatch wb_we_o got %h expected %h (access %0d)",
						wb_we_i, bus_we_i[bus_seen], bus_seen);
					mismatches++;
				end
				if (wb_adr_i !== bus_adr_i[bus_seen]) begin
					$display("mismatch wb_adr_o got %h expected %h (access %0d)",
						wb_adr_i, bus_adr_i[bus_seen], bus_seen);
					mismatches++;
				end
			end
			bus_seen++;
		end
		cyc_q <= wb_cyc_i;
		rst_q <= rst_n;
		if (done_i && !report_done_o) begin
			if (wb_seen_o < exp_count_i) begin
				$display("missing write-backs, saw %0d of %0d", wb_seen_o, exp_count_i);
				other_errs++;
			end
			if (bus_seen < bus_count_i) begin
				$display("missing bus accesses, saw %0d of %0d", bus_seen, bus_count_i);
				other_errs++;
			end
			$display("errors: mismatches %0d, other %0d, write-backs %0d, bus accesses %0d",
				mismatches, other_errs, wb_seen_o, bus_seen);
			report_done_o <= 1'b1;
		end
	end

endmodule : tb_checker

/* test/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule : tb_clock

/* design/backend_top.sv */
`include "backend_params.svh"

module backend_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              issue_valid_i,
	input  backend_pkg::op_e                  issue_op_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    issue_rd_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    issue_rj_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    issue_rk_i,
	input  logic [19:0]                       issue_imm_i,
	output logic                              issue_ready_o,
	output logic                              reg_w_en_o,
	output logic [$clog2(`BE_REG_NUM)-1:0]    reg_w_addr_o,
	output logic [`BE_XLEN-1:0]               reg_w_data_o,
	output logic                              wb_cyc_o,
	output logic                              wb_we_o,
	output logic [`BE_RAM_AW-1:0]             wb_adr_o
);
	logic [$clog2(`BE_REG_NUM)-1:0] ra_addr, rb_addr;
	logic [`BE_XLEN-1:0]            ra_data, rb_data;
	logic                           lsu_req, lsu_we, lsu_busy;
	logic [`BE_XLEN-1:0]            lsu_addr, lsu_wdata, lsu_rdata;
	logic                           wb_stb, wb_ack;
	logic [`BE_XLEN-1:0]            wb_dat_w, wb_dat_r;

	reg_file i_rf (
		.clk, .rst_n,
		.ra_addr_i (ra_addr), .rb_addr_i (rb_addr),
		.ra_data_o (ra_data), .rb_data_o (rb_data),
		.w_en_i (reg_w_en_o), .w_addr_i (reg_w_addr_o), .w_data_i (reg_w_data_o)
	);

	backend_pipeline i_pipe (
		.clk, .rst_n,
		.issue_valid_i, .issue_op_i, .issue_rd_i, .issue_rj_i, .issue_rk_i,
		.issue_imm_i, .issue_ready_o,
		.rf_ra_addr_o (ra_addr), .rf_rb_addr_o (rb_addr),
		.rf_ra_data_i (ra_data), .rf_rb_data_i (rb_data),
		.lsu_req_o (lsu_req), .lsu_we_o (lsu_we), .lsu_addr_o (lsu_addr),
		.lsu_wdata_o (lsu_wdata), .lsu_busy_i (lsu_busy), .lsu_rdata_i (lsu_rdata),
		.reg_w_en_o, .reg_w_addr_o, .reg_w_data_o
	);

	// bus nets double as the observation outputs
	lsu_wb i_lsu (
		.clk, .rst_n,
		.req_i (lsu_req), .we_i (lsu_we), .addr_i (lsu_addr), .wdata_i (lsu_wdata),
		.busy_o (lsu_busy), .rdata_o (lsu_rdata),
		.wb_cyc_o (wb_cyc_o), .wb_stb_o (wb_stb), .wb_we_o (wb_we_o),
		.wb_adr_o (wb_adr_o), .wb_dat_o (wb_dat_w), .wb_dat_i (wb_dat_r),
		.wb_ack_i (wb_ack)
	);

	data_ram i_ram (
		.clk, .rst_n,
		.wb_cyc_i (wb_cyc_o), .wb_stb_i (wb_stb), .wb_we_i (wb_we_o),
		.wb_adr_i (wb_adr_o), .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r),
		.wb_ack_o (wb_ack)
	);

endmodule : backend_top

/* design/backend_pipeline.sv */
`include "backend_params.svh"

module backend_pipeline (
	input  logic                              clk,
	input  logic                              rst_n,

	input  logic                              issue_valid_i,
	input  backend_pkg::op_e                  issue_op_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    issue_rd_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    issue_rj_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    issue_rk_i,
	input  logic [19:0]                       issue_imm_i,
	output logic                              issue_ready_o,

	output logic [$clog2(`BE_REG_NUM)-1:0]    rf_ra_addr_o,
	output logic [$clog2(`BE_REG_NUM)-1:0]    rf_rb_addr_o,
	input  logic [`BE_XLEN-1:0]               rf_ra_data_i,
	input  logic [`BE_XLEN-1:0]               rf_rb_data_i,

	output logic                              lsu_req_o,
	output logic                              lsu_we_o,
	output logic [`BE_XLEN-1:0]               lsu_addr_o,
	output logic [`BE_XLEN-1:0]               lsu_wdata_o,
	input  logic                              lsu_busy_i,
	input  logic [`BE_XLEN-1:0]               lsu_rdata_i,

	output logic                              reg_w_en_o,
	output logic [$clog2(`BE_REG_NUM)-1:0]    reg_w_addr_o,
	output logic [`BE_XLEN-1:0]               reg_w_data_o
);
	import backend_pkg::*;

	localparam int RW = $clog2(`BE_REG_NUM);

	function automatic logic uses_rk(input op_e op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SLL, OP_SRL, OP_SLT, OP_ST_W: uses_rk = 1'b1;
			default:                         uses_rk = 1'b0;
		endcase
	endfunction

	function automatic logic writes_rd(input op_e op, input logic [RW-1:0] rd);
		writes_rd = (op != OP_NOP) && (op != OP_ST_W) && (rd != '0);
	endfunction

	logic run_q; // low only while in reset

	// stage registers
	logic                ex_valid, m1_valid, m2_valid;
	op_e                 ex_op, m1_op, m2_op;
	logic [RW-1:0]       ex_rd, ex_rj, ex_rk, m1_rd, m2_rd;
	logic [`BE_XLEN-1:0] ex_a, ex_b;
	logic [19:0]         ex_imm;
	wb_sel_e             m1_sel, m2_sel;
	logic [`BE_XLEN-1:0] m1_res, m2_res, m1_wdata, m2_wdata;
	logic                wb_en;
	logic [RW-1:0]       wb_rd;
	logic [`BE_XLEN-1:0] wb_data;

	logic                m2_stall, load_use, ex_hold;
	logic                m1_fwd_ok, m2_fwd_ok;
	logic [`BE_XLEN-1:0] a_fwd, b_fwd, alu_res, m2_result;

	assign m2_stall = lsu_busy_i;
	assign load_use = ex_valid && m1_valid && m1_op == OP_LD_W && m1_rd != '0 &&
	                  ((ex_op != OP_NOP && ex_op != OP_LU12I && ex_rj == m1_rd) ||
	                   (uses_rk(ex_op) && ex_rk == m1_rd));
	assign ex_hold  = m2_stall || load_use;

	assign issue_ready_o = run_q && !ex_hold;
	assign rf_ra_addr_o  = issue_rj_i;
	assign rf_rb_addr_o  = issue_rk_i;

	// loads in m1 have no data yet
	assign m1_fwd_ok = m1_valid && writes_rd(m1_op, m1_rd) && m1_sel == WB_ALU;
	assign m2_fwd_ok = m2_valid && writes_rd(m2_op, m2_rd);

	assign m2_result = (m2_sel == WB_LSU) ? lsu_rdata_i : m2_res;

	// youngest producer wins
	always_comb begin
		a_fwd = ex_a;
		if (m1_fwd_ok && m1_rd == ex_rj)      a_fwd = m1_res;
		else if (m2_fwd_ok && m2_rd == ex_rj) a_fwd = m2_result;
		else if (wb_en && wb_rd == ex_rj)     a_fwd = wb_data;

		b_fwd = ex_b;
		if (m1_fwd_ok && m1_rd == ex_rk)      b_fwd = m1_res;
		else if (m2_fwd_ok && m2_rd == ex_rk) b_fwd = m2_result;
		else if (wb_en && wb_rd == ex_rk)     b_fwd = wb_data;
	end

	exec_alu i_alu (
		.op_i  (ex_op),
		.a_i   (a_fwd),
		.b_i   (b_fwd),
		.imm_i (ex_imm),
		.res_o (alu_res)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			run_q    <= 1'b0;
			ex_valid <= 1'b0;
			m1_valid <= 1'b0;
			m2_valid <= 1'b0;
			wb_en    <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (!ex_hold)  ex_valid <= issue_valid_i && run_q;
			if (!m2_stall) m1_valid <= ex_valid && !load_use; // bubble on load-use
			if (!m2_stall) m2_valid <= m1_valid;
			wb_en <= m2_valid && !m2_stall && writes_rd(m2_op, m2_rd);
		end
	end

	// ex payload; keep refreshing forwarded operands while held
	always_ff @(posedge clk) begin
		if (!ex_hold) begin
			ex_op  <= issue_op_i;
			ex_rd  <= issue_rd_i;
			ex_rj  <= issue_rj_i;
			ex_rk  <= issue_rk_i;
			ex_imm <= issue_imm_i;
			ex_a   <= rf_ra_data_i;
			ex_b   <= rf_rb_data_i;
		end else begin
			ex_a <= a_fwd;
			ex_b <= b_fwd;
		end
	end

	always_ff @(posedge clk) begin
		if (!m2_stall) begin
			m1_op    <= ex_op;
			m1_rd    <= ex_rd;
			m1_sel   <= (ex_op == OP_LD_W) ? WB_LSU : WB_ALU;
			m1_res   <= alu_res; // address for ld/st
			m1_wdata <= b_fwd;   // store data from rk
			m2_op    <= m1_op;
			m2_rd    <= m1_rd;
			m2_sel   <= m1_sel;
			m2_res   <= m1_res;
			m2_wdata <= m1_wdata;
		end
		wb_rd   <= m2_rd;
		wb_data <= m2_result;
	end

	assign lsu_req_o   = m2_valid && (m2_op == OP_LD_W || m2_op == OP_ST_W);
	assign lsu_we_o    = m2_op == OP_ST_W;
	assign lsu_addr_o  = m2_res;
	assign lsu_wdata_o = m2_wdata;

	assign reg_w_en_o   = wb_en;
	assign reg_w_addr_o = wb_rd;
	assign reg_w_data_o = wb_data;

endmodule : backend_pipeline

/* design/data_ram.sv */
`include "backend_params.svh"

module data_ram (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  logic [`BE_RAM_AW-1:0]   wb_adr_i,
	input  logic [`BE_XLEN-1:0]     wb_dat_i,
	output logic [`BE_XLEN-1:0]     wb_dat_o,
	output logic                    wb_ack_o
);
	logic [`BE_XLEN-1:0] mem [2**`BE_RAM_AW];
	logic                req; // new strobed access, not yet acked

	assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

	// single ack per access; master still holds stb during the ack cycle
	always_ff @(posedge clk) begin
		if (!rst_n) wb_ack_o <= 1'b0;
		else        wb_ack_o <= req;
	end

	always_ff @(posedge clk) begin
		if (req) wb_dat_o <= mem[wb_adr_i]; // valid with ack
	end

	// store lands on the ack cycle
	always_ff @(posedge clk) begin
		if (wb_cyc_i && wb_stb_i && wb_we_i && wb_ack_o) begin
			mem[wb_adr_i] <= wb_dat_i;
		end
	end

endmodule : data_ram

/* design/lsu_wb.sv */
`include "backend_params.svh"

module lsu_wb (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    req_i,   // m2 holds a load or store
	input  logic                    we_i,
	input  logic [`BE_XLEN-1:0]     addr_i,  // byte address
	input  logic [`BE_XLEN-1:0]     wdata_i,
	output logic                    busy_o,
	output logic [`BE_XLEN-1:0]     rdata_o,

	output logic                    wb_cyc_o,
	output logic                    wb_stb_o,
	output logic                    wb_we_o,
	output logic [`BE_RAM_AW-1:0]   wb_adr_o,
	output logic [`BE_XLEN-1:0]     wb_dat_o,
	input  logic [`BE_XLEN-1:0]     wb_dat_i,
	input  logic                    wb_ack_i
);
	import backend_pkg::*;

	lsu_state_e state_q, state_d;
	logic       active; // strobe out this cycle

	always_comb begin
		state_d = state_q;
		case (state_q)
			LSU_IDLE: if (req_i) state_d = LSU_BUS;
			LSU_BUS:  if (wb_ack_i) state_d = LSU_DONE;
			LSU_DONE: state_d = LSU_IDLE; // m2 moves on this cycle
			default:  state_d = LSU_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) state_q <= LSU_IDLE;
		else        state_q <= state_d;
	end

	// load data captured on ack and held through done
	always_ff @(posedge clk) begin
		if (state_q == LSU_BUS && wb_ack_i && !we_i) rdata_o <= wb_dat_i;
	end

	// first strobe cycle comes straight from the request
	assign active = (state_q == LSU_IDLE && req_i) || (state_q == LSU_BUS);

	assign wb_cyc_o = active;
	assign wb_stb_o = active;
	assign wb_we_o  = we_i;
	assign wb_adr_o = addr_i[`BE_RAM_AW+1:2]; // word index

	assign wb_dat_o = wdata_i;

	// done state releases the pipe
	assign busy_o = active;

endmodule : lsu_wb

/* design/exec_alu.sv */
`include "backend_params.svh"

module exec_alu (
	input  backend_pkg::op_e       op_i,
	input  logic [`BE_XLEN-1:0]    a_i,
	input  logic [`BE_XLEN-1:0]    b_i,
	input  logic [19:0]            imm_i, // si12 in [11:0], or ui20 for lu12i
	output logic [`BE_XLEN-1:0]    res_o
);
	import backend_pkg::*;

	logic [`BE_XLEN-1:0] imm_sext;
	logic [`BE_XLEN-1:0] imm_upper;
	logic [4:0]          shamt;

	assign imm_sext  = {{(`BE_XLEN-12){imm_i[11]}}, imm_i[11:0]};
	assign imm_upper = {imm_i, 12'd0};
	assign shamt     = b_i[4:0];

	always_comb begin
		res_o = '0;
		case (op_i)
			OP_ADD:   res_o = a_i + b_i;
			OP_SUB:   res_o = a_i - b_i;
			OP_AND:   res_o = a_i & b_i;
			OP_OR:    res_o = a_i | b_i;
			OP_XOR:   res_o = a_i ^ b_i;
			OP_SLL:   res_o = a_i << shamt;
			OP_SRL:   res_o = a_i >> shamt;
			OP_SLT: begin
				res_o = {{(`BE_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
			end
			// loads and stores share this adder as the agu
			OP_ADDI,
			OP_LD_W,
			OP_ST_W:  res_o = a_i + imm_sext;
			OP_LU12I: res_o = imm_upper;
			default:  res_o = '0; // nop
		endcase
	end

endmodule : exec_alu

/* design/reg_file.sv */
`include "backend_params.svh"

module reg_file (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    ra_addr_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    rb_addr_i,
	output logic [`BE_XLEN-1:0]               ra_data_o,
	output logic [`BE_XLEN-1:0]               rb_data_o,
	input  logic                              w_en_i,
	input  logic [$clog2(`BE_REG_NUM)-1:0]    w_addr_i,
	input  logic [`BE_XLEN-1:0]               w_data_i
);
	logic [`BE_XLEN-1:0] regs [`BE_REG_NUM];
	logic                w_live; // a real write this cycle

	assign w_live = w_en_i && (w_addr_i != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `BE_REG_NUM; i++) regs[i] <= '0;
		end else if (w_live) begin
			regs[w_addr_i] <= w_data_i; // r0 never written
		end
	end

	// write-through so the issuing instruction sees the wb result
	assign ra_data_o = (w_live && w_addr_i == ra_addr_i) ? w_data_i : regs[ra_addr_i];
	assign rb_data_o = (w_live && w_addr_i == rb_addr_i) ? w_data_i : regs[rb_addr_i];

endmodule : reg_file

/* design/backend_pkg.sv */
package backend_pkg;

	// instruction opcodes seen by the back end
	typedef enum logic [3:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_AND   = 4'd3,
		OP_OR    = 4'd4,
		OP_XOR   = 4'd5,
		OP_SLL   = 4'd6,
		OP_SRL   = 4'd7,
		OP_SLT   = 4'd8,  // signed compare
		OP_ADDI  = 4'd9,  // rj + sext(imm12)
		OP_LU12I = 4'd10, // imm20 << 12
		OP_LD_W  = 4'd11, // rd = mem[rj + sext(imm12)]
		OP_ST_W  = 4'd12  // mem[rj + sext(imm12)] = rk
	} op_e;

	// where the write-back value comes from
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_LSU = 1'b1
	} wb_sel_e;

	// lsu bus sequencing
	typedef enum logic [1:0] {
		LSU_IDLE = 2'd0, // strobe goes out here when a request shows up
		LSU_BUS  = 2'd1, // waiting for ack
		LSU_DONE = 2'd2  // data valid, m2 may advance
	} lsu_state_e;

endpackage : backend_pkg

/* design/backend_params.svh */
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

// datapath and byte address width
`define BE_XLEN 32

// architectural integer registers, r0 hardwired to zero
`define BE_REG_NUM 32

// data ram word address width (256 words)
`define BE_RAM_AW 8

`endif
